// ==== src/dl1c_macros.svh ====
`ifndef DL1C_MACROS_SVH
`define DL1C_MACROS_SVH

// Cache geometry: 2 ways, 16 sets, 32-byte lines
`define DL1C_SET_BITS 4
`define DL1C_NUM_SETS 16

// Word index within a line
`define DL1C_WORD_SEL_BITS 3

// Address bits above the set field (byte address bits 31 to 9)
`define DL1C_TAG_BITS 23

`define DL1C_LINE_BITS 256
`define DL1C_LINE_BYTES 32

// L2 opcodes
`define DL1C_OPC_READ 3'd0
`define DL1C_OPC_WRITE 3'd1

`endif

// ==== src/dl1c_pkg.sv ====
`include "dl1c_macros.svh"

package dl1c_pkg;

   typedef logic [31:0] word_t;

   // Byte address bits 31 to 2
   typedef logic [29:0] word_addr_t;

   // Byte address bits 31 to 5
   typedef logic [`DL1C_TAG_BITS+`DL1C_SET_BITS-1:0] line_addr_t;

   // Address fields, top to bottom
   typedef logic [`DL1C_TAG_BITS-1:0] tag_t;
   typedef logic [`DL1C_SET_BITS-1:0] set_t;
   typedef logic [`DL1C_WORD_SEL_BITS-1:0] word_sel_t;

   typedef logic [3:0] byte_en_t;
   typedef logic [`DL1C_LINE_BITS-1:0] line_t;
   typedef logic [`DL1C_LINE_BYTES-1:0] line_be_t;
   typedef logic [2:0] l2_opc_t;

   // One word request from the processor
   typedef struct packed {
      word_addr_t addr;
      logic re;
      byte_en_t we;
      word_t wdata;
   } cpu_req_t;

   // Line request towards L2
   typedef struct packed {
      logic valid;
      l2_opc_t opcode;
      line_addr_t addr;
      line_t wdata;
      line_be_t wbe;
   } l2_req_t;

   typedef enum logic [1:0] {ST_LOOKUP, ST_FILL, ST_WRITE} ctrl_state_t;

endpackage

// ==== src/dl1c_ram.sv ====
`timescale 1ns/100ps

module dl1c_ram #(
   parameter int DATA_WIDTH = 32,
   parameter int ADDR_WIDTH = 4
) (
   input logic clk,
   input dl1c_pkg::set_t addr,
   input logic we,
   input logic [DATA_WIDTH-1:0] wdata,
   output logic [DATA_WIDTH-1:0] rdata
);

   logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

   // Write-first: a write shows up on the read port in the next cycle
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
         rdata <= wdata;
      end else begin
         rdata <= mem[addr];
      end
   end

endmodule

// ==== src/dl1c_ways.sv ====
`timescale 1ns/100ps

`include "dl1c_macros.svh"

module dl1c_ways (
   input logic clk,
   input logic reset,
   input logic flush,

   // Set presented to the RAMs, tag compared one cycle later
   input dl1c_pkg::set_t lookup_set,
   input dl1c_pkg::tag_t tag,

   input logic fill,
   input logic write,
   input dl1c_pkg::line_t wr_line,

   output logic hit,
   output dl1c_pkg::line_t hit_line
);

   // Set the RAM outputs belong to
   dl1c_pkg::set_t set_q;

   logic [1:0][`DL1C_NUM_SETS-1:0] valid_q;

   // Per set, the way to replace on the next fill
   logic [`DL1C_NUM_SETS-1:0] victim_q;

   dl1c_pkg::tag_t tag_rd [2];
   dl1c_pkg::line_t line_rd [2];

   logic [1:0] way_hit;
   logic [1:0] tag_we;
   logic [1:0] data_we;
   logic hit_way;
   logic victim;

   assign victim = victim_q[set_q];

   for (genvar w = 0; w < 2; w++) begin : g_way
      assign way_hit[w] = valid_q[w][set_q] & (tag_rd[w] == tag);

      // Fill goes to the victim, a write to the way that hit
      assign tag_we[w] = fill & (victim == 1'(w));
      assign data_we[w] = tag_we[w] | (write & way_hit[w]);

      dl1c_ram #(
         .DATA_WIDTH (`DL1C_TAG_BITS),
         .ADDR_WIDTH (`DL1C_SET_BITS)
      ) u_tag_ram (
         .clk   (clk),
         .addr  (lookup_set),
         .we    (tag_we[w]),
         .wdata (tag),
         .rdata (tag_rd[w])
      );

      dl1c_ram #(
         .DATA_WIDTH (`DL1C_LINE_BITS),
         .ADDR_WIDTH (`DL1C_SET_BITS)
      ) u_data_ram (
         .clk   (clk),
         .addr  (lookup_set),
         .we    (data_we[w]),
         .wdata (wr_line),
         .rdata (line_rd[w])
      );
   end

   assign hit = |way_hit;

   // Only one way can match, so way 1 hitting names the hit way
   assign hit_way = way_hit[1];
   assign hit_line = line_rd[hit_way];

   always_ff @(posedge clk) begin
      if (reset) begin
         set_q <= '0;
      end else begin
         set_q <= lookup_set;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         valid_q <= '0;
         victim_q <= '0;
      end else begin
         if (fill) begin
            valid_q[victim][set_q] <= 1'b1;
         end
         // Other way becomes the next victim
         if (hit) begin
            victim_q[set_q] <= ~hit_way;
         end
      end
   end

endmodule

// ==== src/dl1c_ctrl.sv ====
`timescale 1ns/100ps

`include "dl1c_macros.svh"

module dl1c_ctrl (
   input logic clk,
   input logic reset,

   // Processor side
   input dl1c_pkg::cpu_req_t cpu_req,
   output logic ready,
   output dl1c_pkg::word_t rdata,

   // L2 side
   output dl1c_pkg::l2_req_t l2_req,
   input logic l2_stall,
   input logic l2_rvalid,
   input dl1c_pkg::line_t l2_rdata,

   // Way storage
   output dl1c_pkg::set_t lookup_set,
   output dl1c_pkg::tag_t tag,
   output logic fill,
   output logic write,
   output dl1c_pkg::line_t wr_line,
   input logic hit,
   input dl1c_pkg::line_t hit_line
);

   dl1c_pkg::cpu_req_t req_q;
   dl1c_pkg::ctrl_state_t state_q;
   dl1c_pkg::ctrl_state_t state_d;
   dl1c_pkg::l2_req_t l2_q;
   dl1c_pkg::l2_req_t l2_d;

   dl1c_pkg::set_t in_set;
   dl1c_pkg::set_t req_set;
   dl1c_pkg::word_sel_t word_sel;
   dl1c_pkg::line_addr_t line_addr;
   dl1c_pkg::line_t merged_line;
   dl1c_pkg::line_be_t line_be;

   logic req_real;
   logic issue_read;
   logic issue_write;
   logic accepted;

   // Address fields of the incoming and the held request
   assign in_set = cpu_req.addr[`DL1C_WORD_SEL_BITS +: `DL1C_SET_BITS];
   assign req_set = req_q.addr[`DL1C_WORD_SEL_BITS +: `DL1C_SET_BITS];
   assign tag = req_q.addr[`DL1C_WORD_SEL_BITS+`DL1C_SET_BITS +: `DL1C_TAG_BITS];
   assign word_sel = req_q.addr[0 +: `DL1C_WORD_SEL_BITS];
   assign line_addr = req_q.addr[`DL1C_WORD_SEL_BITS +: `DL1C_TAG_BITS+`DL1C_SET_BITS];

   // Look up the next request as soon as this one is done
   assign lookup_set = ready ? in_set : req_set;

   assign req_real = req_q.re | (|req_q.we);
   assign accepted = l2_q.valid & ~l2_stall;

   always_comb begin
      state_d = state_q;
      ready = 1'b0;
      issue_read = 1'b0;
      issue_write = 1'b0;
      fill = 1'b0;
      case (state_q)
         dl1c_pkg::ST_LOOKUP: begin
            if (!req_real) begin
               ready = 1'b1;
            end else if (!hit) begin
               // Miss, also ahead of a write
               if (!l2_stall) begin
                  issue_read = 1'b1;
                  state_d = dl1c_pkg::ST_FILL;
               end
            end else if (|req_q.we) begin
               if (!l2_stall) begin
                  issue_write = 1'b1;
                  state_d = dl1c_pkg::ST_WRITE;
               end
            end else begin
               ready = 1'b1;
            end
         end
         dl1c_pkg::ST_FILL: begin
            if (l2_rvalid && !l2_stall) begin
               fill = 1'b1;
               state_d = dl1c_pkg::ST_LOOKUP;
            end
         end
         dl1c_pkg::ST_WRITE: begin
            if (accepted) begin
               state_d = dl1c_pkg::ST_LOOKUP;
            end
         end
         default: state_d = dl1c_pkg::ST_LOOKUP;
      endcase
   end

   assign write = issue_write;

   // Byte-enable merge of the write word into the hit line
   always_comb begin
      merged_line = hit_line;
      for (int b = 0; b < 4; b++) begin
         if (req_q.we[b]) begin
            merged_line[word_sel*32 + b*8 +: 8] = req_q.wdata[b*8 +: 8];
         end
      end
   end

   assign line_be = dl1c_pkg::line_be_t'(req_q.we) << (word_sel * 4);
   assign wr_line = fill ? l2_rdata : merged_line;
   assign rdata = hit_line[word_sel*32 +: 32];

   // Next L2 request, loaded only while not stalled
   always_comb begin
      l2_d = l2_q;
      if (accepted) begin
         l2_d.valid = 1'b0;
      end
      if (issue_read) begin
         l2_d.valid = 1'b1;
         l2_d.opcode = `DL1C_OPC_READ;
         l2_d.addr = line_addr;
         l2_d.wbe = '0;
      end
      if (issue_write) begin
         l2_d.valid = 1'b1;
         l2_d.opcode = `DL1C_OPC_WRITE;
         l2_d.addr = line_addr;
         l2_d.wdata = merged_line;
         l2_d.wbe = line_be;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= dl1c_pkg::ST_LOOKUP;
         req_q.re <= 1'b0;
         req_q.we <= '0;
         l2_q.valid <= 1'b0;
      end else begin
         state_q <= state_d;
         if (ready) begin
            req_q <= cpu_req;
         end else if (issue_write) begin
            // Write done in the cache, a pending read part still completes
            req_q.we <= '0;
         end
         if (!l2_stall) begin
            l2_q <= l2_d;
         end
      end
   end

   assign l2_req = l2_q;

endmodule

// ==== src/dl1c_top.sv ====
`timescale 1ns/100ps

module dl1c_top (
   input logic clk,
   input logic reset,
   input logic flush,

   input dl1c_pkg::cpu_req_t cpu_req,
   output logic ready,
   output dl1c_pkg::word_t rdata,

   output dl1c_pkg::l2_req_t l2_req,
   input logic l2_stall,
   input logic l2_rvalid,
   input dl1c_pkg::line_t l2_rdata
);

   dl1c_pkg::set_t lookup_set;
   dl1c_pkg::tag_t tag;
   dl1c_pkg::line_t wr_line;
   dl1c_pkg::line_t hit_line;
   logic fill;
   logic write;
   logic hit;

   dl1c_ctrl u_ctrl (
      .clk        (clk),
      .reset      (reset),
      .cpu_req    (cpu_req),
      .ready      (ready),
      .rdata      (rdata),
      .l2_req     (l2_req),
      .l2_stall   (l2_stall),
      .l2_rvalid  (l2_rvalid),
      .l2_rdata   (l2_rdata),
      .lookup_set (lookup_set),
      .tag        (tag),
      .fill       (fill),
      .write      (write),
      .wr_line    (wr_line),
      .hit        (hit),
      .hit_line   (hit_line)
   );

   dl1c_ways u_ways (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .lookup_set (lookup_set),
      .tag        (tag),
      .fill       (fill),
      .write      (write),
      .wr_line    (wr_line),
      .hit        (hit),
      .hit_line   (hit_line)
   );

endmodule

// ==== verif/dl1c_asserts.sv ====
`timescale 1ns/100ps

module dl1c_asserts (
   input logic clk,
   input logic reset,
   input logic ready,
   input dl1c_pkg::l2_req_t l2_req,
   input logic l2_stall
);

   // Whole L2 request frozen while stalled
   a_req_stable: assert property (
      @(posedge clk) disable iff (reset)
      (l2_req.valid && l2_stall) |=> $stable(l2_req)
   ) else $error("L2 request changed while it was valid and stalled");

   // Cache comes out of reset able to take a request
   a_ready_after_reset: assert property (
      @(posedge clk) reset |=> ready
   ) else $error("ready was low in the cycle after reset");

   // No L2 traffic pending while the processor side is idle
   a_no_req_when_ready: assert property (
      @(posedge clk) disable iff (reset)
      ready |-> !l2_req.valid
   ) else $error("L2 request valid while ready was high");

endmodule

// ==== verif/dl1c_checker.sv ====
`timescale 1ns/100ps

`include "dl1c_macros.svh"

module dl1c_checker (
   input logic clk,
   input logic reset,
   input logic flush,
   input dl1c_pkg::cpu_req_t cpu_req,
   input logic ready,
   input dl1c_pkg::word_t rdata,
   input dl1c_pkg::l2_req_t l2_req,
   input logic l2_stall,
   output int error_count,
   output int check_count
);

   logic [31:0] mem [logic [29:0]];

   // Mirror of tags, valid bits and victims
   dl1c_pkg::tag_t tag_m [`DL1C_NUM_SETS][2];
   logic valid_m [`DL1C_NUM_SETS][2];
   logic victim_m [`DL1C_NUM_SETS];

   dl1c_pkg::cpu_req_t pend;
   logic pend_valid;
   logic pend_hit;
   logic pend_way;
   int reads_seen;
   int writes_seen;

   initial begin
      error_count = 0;
      check_count = 0;
      pend_valid = 1'b0;
   end

   function automatic logic [31:0] mem_word(input logic [29:0] a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      return {2'b00, a} ^ 32'h5a5a_0000;
   endfunction

   task automatic report_error(input string msg);
      error_count++;
      $display("FAILED at %0t: %s", $time, msg);
   endtask

   task automatic clear_model();
      for (int s = 0; s < `DL1C_NUM_SETS; s++) begin
         valid_m[s][0] = 1'b0;
         valid_m[s][1] = 1'b0;
         victim_m[s] = 1'b0;
      end
   endtask

   task automatic start_request(input dl1c_pkg::cpu_req_t r);
      dl1c_pkg::set_t s;
      dl1c_pkg::tag_t t;
      s = r.addr[3 +: 4];
      t = r.addr[7 +: 23];
      pend = r;
      pend_valid = r.re | (|r.we);
      pend_hit = 1'b0;
      pend_way = 1'b0;
      reads_seen = 0;
      writes_seen = 0;
      for (int w = 0; w < 2; w++) begin
         if (valid_m[s][w] && tag_m[s][w] == t) begin
            pend_hit = 1'b1;
            pend_way = 1'(w);
         end
      end
   endtask

   task automatic check_l2(input dl1c_pkg::l2_req_t r);
      logic [2:0] ws;
      logic [31:0] v;
      dl1c_pkg::line_be_t exp_be;
      ws = pend.addr[2:0];
      check_count++;
      if (!pend_valid) begin
         report_error("L2 request with no processor request in flight");
      end else if (r.addr != pend.addr[29:3]) begin
         report_error($sformatf("L2 address %h, expected %h", r.addr, pend.addr[29:3]));
      end else if (r.opcode == `DL1C_OPC_READ) begin
         reads_seen++;
         if (pend_hit) begin
            report_error($sformatf("L2 read for cached line %h", r.addr));
         end
      end else if (r.opcode == `DL1C_OPC_WRITE) begin
         writes_seen++;
         // Four enables of the word slot, all other line bytes off
         exp_be = '0;
         for (int b = 0; b < 4; b++) begin
            exp_be[ws*4 + b] = pend.we[b];
         end
         if (r.wbe != exp_be) begin
            report_error($sformatf("L2 wbe %h, expected %h", r.wbe, exp_be));
         end
         v = mem_word(pend.addr);
         for (int b = 0; b < 4; b++) begin
            if (pend.we[b]) begin
               if (r.wdata[ws*32 + b*8 +: 8] != pend.wdata[b*8 +: 8]) begin
                  report_error($sformatf("L2 write byte %0d wrong", b));
               end
               v[b*8 +: 8] = pend.wdata[b*8 +: 8];
            end
         end
         mem[pend.addr] = v;
      end else begin
         report_error($sformatf("unknown L2 opcode %0d", r.opcode));
      end
   endtask

   task automatic finish_request();
      dl1c_pkg::set_t s;
      logic [31:0] exp;
      s = pend.addr[3 +: 4];
      check_count++;
      if (reads_seen != (pend_hit ? 0 : 1)) begin
         report_error($sformatf("%0d L2 reads for %h, hit %0b", reads_seen, pend.addr, pend_hit));
      end
      if (writes_seen != ((|pend.we) ? 1 : 0)) begin
         report_error($sformatf("%0d L2 writes for %h", writes_seen, pend.addr));
      end
      if (pend.re) begin
         exp = mem_word(pend.addr);
         if (rdata !== exp) begin
            report_error($sformatf("read %h gave %h, expected %h", pend.addr, rdata, exp));
         end
      end
      // Miss fills the victim way and the other way becomes the next victim
      if (!pend_hit) begin
         pend_way = victim_m[s];
         tag_m[s][pend_way] = pend.addr[7 +: 23];
         valid_m[s][pend_way] = 1'b1;
      end
      victim_m[s] = ~pend_way;
   endtask

   always @(posedge clk) begin
      if (reset) begin
         clear_model();
         pend_valid = 1'b0;
      end else begin
         if (l2_req.valid && !l2_stall) begin
            check_l2(l2_req);
         end
         if (ready) begin
            if (pend_valid) begin
               finish_request();
            end
            if (flush) begin
               clear_model();
            end
            start_request(cpu_req);
         end
      end
   end

endmodule

// ==== verif/tb_dl1c.sv ====
`timescale 1ns/100ps

`include "dl1c_macros.svh"

module tb_dl1c;

   localparam int NUM_REQS = 400;
   localparam int TIMEOUT_CYCLES = NUM_REQS * 40;
   localparam logic [22:0] NOOP_TAG = '1;

   logic clk = 1'b0;
   logic reset;
   logic flush;
   dl1c_pkg::cpu_req_t cpu_req;
   logic ready;
   dl1c_pkg::word_t rdata;
   dl1c_pkg::l2_req_t l2_req;
   logic l2_stall;
   logic l2_rvalid;
   dl1c_pkg::line_t l2_rdata;

   int error_count;
   int check_count;
   int cycles = 0;
   logic [31:0] lfsr;

   dl1c_pkg::cpu_req_t reqs [NUM_REQS];
   logic flush_q [NUM_REQS];

   // L2 memory and the one outstanding read
   logic [31:0] l2_mem [logic [29:0]];
   logic rd_pending;
   int rd_wait;
   dl1c_pkg::line_addr_t rd_addr;
   logic [31:0] kind_bits;

   dl1c_top dut (
      .clk       (clk),
      .reset     (reset),
      .flush     (flush),
      .cpu_req   (cpu_req),
      .ready     (ready),
      .rdata     (rdata),
      .l2_req    (l2_req),
      .l2_stall  (l2_stall),
      .l2_rvalid (l2_rvalid),
      .l2_rdata  (l2_rdata)
   );

   dl1c_checker u_checker (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .cpu_req     (cpu_req),
      .ready       (ready),
      .rdata       (rdata),
      .l2_req      (l2_req),
      .l2_stall    (l2_stall),
      .error_count (error_count),
      .check_count (check_count)
   );

   bind dl1c_top dl1c_asserts u_asserts (
      .clk      (clk),
      .reset    (reset),
      .ready    (ready),
      .l2_req   (l2_req),
      .l2_stall (l2_stall)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic logic [31:0] l2_word(input logic [29:0] a);
      if (l2_mem.exists(a)) begin
         return l2_mem[a];
      end
      return {2'b00, a} ^ 32'h5a5a_0000;
   endfunction

   function automatic dl1c_pkg::line_t read_line(input dl1c_pkg::line_addr_t la);
      dl1c_pkg::line_t line;
      for (int w = 0; w < 8; w++) begin
         line[w*32 +: 32] = l2_word({la, 3'(w)});
      end
      return line;
   endfunction

   task automatic write_line(input dl1c_pkg::l2_req_t r);
      logic [29:0] a;
      logic [31:0] v;
      for (int w = 0; w < 8; w++) begin
         a = {r.addr, 3'(w)};
         v = l2_word(a);
         for (int b = 0; b < 4; b++) begin
            if (r.wbe[w*4 + b]) begin
               v[b*8 +: 8] = r.wdata[w*32 + b*8 +: 8];
            end
         end
         if (|r.wbe[w*4 +: 4]) begin
            l2_mem[a] = v;
         end
      end
   endtask

   // Four tags over four sets and no-ops on a tag that is never cached
   task automatic build_requests();
      logic [31:0] kind, t, s, w, be, d;
      logic flush_next;
      flush_next = 1'b0;
      for (int i = 0; i < NUM_REQS; i++) begin
         take_bits(3, kind);
         take_bits(2, t);
         take_bits(2, s);
         take_bits(3, w);
         take_bits(4, be);
         take_bits(32, d);
         reqs[i].addr = {23'(t[1:0]) + 23'd1, 2'b00, s[1:0], w[2:0]};
         reqs[i].re = (kind < 4);
         reqs[i].we = (kind == 4 || kind == 5) ? ((be[3:0] == 0) ? 4'hf : be[3:0]) : 4'h0;
         reqs[i].wdata = d;
         if (kind >= 6) begin
            reqs[i].addr[29:7] = NOOP_TAG;
         end
         flush_q[i] = flush_next;
         flush_next = (kind == 7);
      end
   endtask

   task automatic wait_ready();
      do begin
         @(negedge clk);
      end while (!ready);
   endtask

   // L2 model that accepts at the edge and answers two cycles after a read
   always @(posedge clk) begin
      if (reset) begin
         rd_pending = 1'b0;
         rd_wait = 0;
      end else begin
         if (l2_rvalid) begin
            rd_pending = 1'b0;
         end
         if (l2_req.valid && !l2_stall) begin
            if (l2_req.opcode == `DL1C_OPC_WRITE) begin
               write_line(l2_req);
            end else begin
               rd_pending = 1'b1;
               rd_addr = l2_req.addr;
               rd_wait = 2;
            end
         end else if (rd_wait > 0) begin
            rd_wait--;
         end
      end
      #1;
      if (reset) begin
         l2_stall = 1'b0;
         l2_rvalid = 1'b0;
      end else begin
         take_bits(2, kind_bits);
         l2_stall = &kind_bits[1:0];
         l2_rvalid = rd_pending && rd_wait == 0 && !l2_stall;
         l2_rdata = l2_rvalid ? read_line(rd_addr) : '0;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("Timeout: the cache stopped answering after %0d cycles", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      lfsr = 32'hf9c0;
      reset = 1'b1;
      flush = 1'b0;
      cpu_req = '0;
      l2_stall = 1'b0;
      l2_rvalid = 1'b0;
      l2_rdata = '0;
      build_requests();
      repeat (5) @(posedge clk);
      #1 reset = 1'b0;
      for (int i = 0; i < NUM_REQS; i++) begin
         cpu_req = reqs[i];
         flush = flush_q[i];
         wait_ready();
         @(posedge clk);
         #1 flush = 1'b0;
      end
      cpu_req = '0;
      wait_ready();
      repeat (3) @(posedge clk);
      $display("Requests: %0d, checks: %0d, errors: %0d", NUM_REQS, check_count, error_count);
      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+src
src/dl1c_pkg.sv
src/dl1c_ram.sv
src/dl1c_ways.sv
src/dl1c_ctrl.sv
src/dl1c_top.sv
verif/dl1c_asserts.sv
verif/dl1c_checker.sv
verif/tb_dl1c.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dl1c -f project.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_dl1c)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
   exit 0
fi
exit 1
